/* Makefile */
# Verilator build and run of the reduction tree testbench

TOP := tb_reduction_tree

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): build.f $(shell cat build.f)
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f build.f -Mdir obj_dir

# assertion errors keep the run going so the testbench can count them
run: compile
	./obj_dir/V$(TOP) +verilator+error+limit+1000 > sim.log 2>&1; \
	status=$$?; \
	cat sim.log; \
	if grep -q "Some tests failed" sim.log; then \
		echo "simulation FAILED"; \
		exit 1; \
	fi; \
	exit $$status

clean:
	rm -rf obj_dir sim.log

/* build.f */
hdl/art_cfg_pkg.sv
hdl/art_data_pkg.sv
hdl/mux_2x1_simple_comb.sv
hdl/adder_switch.sv
hdl/art_config_regs.sv
hdl/reduction_tree.sv
test/reduction_tree_asserts.sv
test/tb_reduction_tree.sv

/* hdl/adder_switch.sv */
`timescale 1ns/10ps

////////////////////////////////////////////////////////////////////////////
// one node of the reduction tree
//   add    -> low + high, needs both children valid
//   !add   -> forward the child picked by sel
//   emit   -> result to own slot, else up to parent
// one register stage per node
////////////////////////////////////////////////////////////////////////////
module adder_switch #(
	parameter int DATA_WIDTH = 32
)(
	input  logic                    i_clk,
	input  logic                    i_reset,
	input  art_cfg_pkg::node_cmd_t  i_cmd,
	input  logic [1:0]              i_valid,
	input  logic [2*DATA_WIDTH-1:0] i_data,
	output logic                    o_up_valid,
	output logic [DATA_WIDTH-1:0]   o_up_data,
	output logic                    o_out_valid,
	output logic [DATA_WIDTH-1:0]   o_out_data
);

	// forward path
	logic                  fwd_valid;
	logic [DATA_WIDTH-1:0] fwd_data;

	// add path
	logic                  sum_valid;
	logic [DATA_WIDTH-1:0] sum_data;

	// selected result before the register
	logic                  res_valid;
	logic [DATA_WIDTH-1:0] res_data;

	////////////////////////////////////////////////////////////////////////////
	// combinational stage
	////////////////////////////////////////////////////////////////////////////

	// mux only active while forwarding
	mux_2x1_simple_comb #(
		.DATA_WIDTH(DATA_WIDTH)
	) u_fwd_mux (
		.i_valid(i_valid),
		.i_data_bus(i_data),
		.i_en(~i_cmd.add),
		.i_cmd(i_cmd.sel),
		.o_valid(fwd_valid),
		.o_data_bus(fwd_data)
	);

	// wrap-around sum, a lone valid child is dropped
	assign sum_valid = i_valid[0] & i_valid[1];
	assign sum_data = i_data[0 +: DATA_WIDTH] + i_data[DATA_WIDTH +: DATA_WIDTH];

	assign res_valid = i_cmd.add ? sum_valid : fwd_valid;
	assign res_data = i_cmd.add ? sum_data : fwd_data;

	////////////////////////////////////////////////////////////////////////////
	// register stage
	////////////////////////////////////////////////////////////////////////////

	// valid strobes, exactly one of the two pairs can fire
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			o_up_valid <= 1'b0;
			o_out_valid <= 1'b0;
		end
		else
		begin
			o_up_valid <= res_valid & ~i_cmd.emit;
			o_out_valid <= res_valid & i_cmd.emit;
		end
	end

	// payload, loaded only on the chosen side
	always_ff @(posedge i_clk)
	begin
		if (res_valid && !i_cmd.emit)
			o_up_data <= res_data;
		if (res_valid && i_cmd.emit)
			o_out_data <= res_data;
	end

endmodule

/* hdl/art_cfg_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// reduction tree configuration types
////////////////////////////////////////////////////////////////////////////
package art_cfg_pkg;

	// seven adder switches in a three-level binary tree
	parameter int NUM_NODES = 7;

	// node numbering, level one first, then level two, root last
	parameter int LEVEL2_BASE = 4;
	parameter int ROOT_NODE = 6;

	// index of one switch, value 7 is not a node
	typedef logic [2:0] node_idx_t;

	// per-switch command word
	// all zero = forward left child upward
	typedef struct packed {
		logic add;    // sum both children
		logic sel;    // forward select, 1 high (right), 0 low (left)
		logic emit;   // result to own output slot, not parent
	} node_cmd_t;

	// tree level of a node, 1 at the leaves, 3 at the root
	function automatic int node_level(input int node);
		if (node >= ROOT_NODE)
			return 3;
		else if (node >= LEVEL2_BASE)
			return 2;
		else
			return 1;
	endfunction

endpackage

/* hdl/art_config_regs.sv */
`timescale 1ns/10ps

////////////////////////////////////////////////////////////////////////////
// per-node command registers
// strobe at edge t, new command in effect from cycle t+1
////////////////////////////////////////////////////////////////////////////
module art_config_regs (
	input  logic                   i_clk,
	input  logic                   i_reset,
	input  logic                   i_cfg_wr,
	input  art_cfg_pkg::node_idx_t i_cfg_node,
	input  art_cfg_pkg::node_cmd_t i_cfg_cmd,
	output art_cfg_pkg::node_cmd_t [art_cfg_pkg::NUM_NODES-1:0] o_node_cmd
);

	// last valid node index
	localparam art_cfg_pkg::node_idx_t LAST_NODE =
		art_cfg_pkg::node_idx_t'(art_cfg_pkg::NUM_NODES - 1);

	// write lands on an existing node
	logic cfg_hit;

	// index 7 has no register behind it
	assign cfg_hit = i_cfg_wr && (i_cfg_node <= LAST_NODE);

	////////////////////////////////////////////////////////////////////////////
	// command storage
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			// all zero, forward left, no emit
			o_node_cmd <= '0;
		end
		else if (cfg_hit)
		begin
			o_node_cmd[i_cfg_node] <= i_cfg_cmd;
		end
	end

endmodule

/* hdl/art_data_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// reduction tree data shape
////////////////////////////////////////////////////////////////////////////
package art_data_pkg;

	// leaf lanes, one partial sum each
	parameter int NUM_LEAVES = 8;

	// switch levels between leaves and root
	// also the latency of the root slot in cycles
	parameter int TREE_DEPTH = 3;

	// default partial-sum width
	// sums wrap at this width, no saturation
	parameter int PSUM_WIDTH_DEF = 32;

endpackage

/* hdl/mux_2x1_simple_comb.sv */
`timescale 1ns/10ps

////////////////////////////////////////////////////////////////////////////
// two-way select, combinational
//   low half  = i_data_bus[0 +: DATA_WIDTH]
//   high half = i_data_bus[DATA_WIDTH +: DATA_WIDTH]
//   i_cmd 1 picks high, 0 picks low
////////////////////////////////////////////////////////////////////////////
module mux_2x1_simple_comb #(
	parameter int DATA_WIDTH = 32,
	parameter int COMMAND_WIDTH = 1
)(
	input  logic [1:0]              i_valid,
	input  logic [2*DATA_WIDTH-1:0] i_data_bus,
	input  logic                    i_en,
	input  logic [COMMAND_WIDTH-1:0] i_cmd,
	output logic                    o_valid,
	output logic [DATA_WIDTH-1:0]   o_data_bus
);

	always_comb
	begin
		// idle value, zero data and valid low
		o_valid = 1'b0;
		o_data_bus = {DATA_WIDTH{1'b0}};
		if (i_en)
		begin
			case ({i_cmd[0], i_valid})
				// low selected and low valid
				3'b001, 3'b011:
				begin
					o_valid = 1'b1;
					o_data_bus = i_data_bus[0 +: DATA_WIDTH];
				end
				// high selected and high valid
				3'b110, 3'b111:
				begin
					o_valid = 1'b1;
					o_data_bus = i_data_bus[DATA_WIDTH +: DATA_WIDTH];
				end
				// selected half not valid, nothing passes
				default:
				begin
					o_valid = 1'b0;
					o_data_bus = {DATA_WIDTH{1'b0}};
				end
			endcase
		end
	end

endmodule

/* hdl/reduction_tree.sv */
`timescale 1ns/10ps

////////////////////////////////////////////////////////////////////////////
// reduction network top
//
//   level 3              node 6
//                       /      \
//   level 2         node 4    node 5
//                   /   \     /   \
//   level 1       n0    n1   n2    n3
//                / \   / \   / \   / \
//   leaves      0   1 2   3 4   5 6   7
//
// slot n valid at edge t + level(n) for a vector taken at edge t
////////////////////////////////////////////////////////////////////////////
module reduction_tree #(
	parameter int DATA_WIDTH = art_data_pkg::PSUM_WIDTH_DEF
)(
	input  logic                   i_clk,
	input  logic                   i_reset,
	input  logic                   i_cfg_wr,
	input  art_cfg_pkg::node_idx_t i_cfg_node,
	input  art_cfg_pkg::node_cmd_t i_cfg_cmd,
	input  logic [art_data_pkg::NUM_LEAVES-1:0]            i_leaf_valid,
	input  logic [art_data_pkg::NUM_LEAVES*DATA_WIDTH-1:0] i_leaf_data,
	output logic [art_cfg_pkg::NUM_NODES-1:0]              o_valid,
	output logic [art_cfg_pkg::NUM_NODES*DATA_WIDTH-1:0]   o_data
);

	// one command per switch
	art_cfg_pkg::node_cmd_t [art_cfg_pkg::NUM_NODES-1:0] node_cmd;

	// upward outputs of every switch, root entry has no parent
	logic [art_cfg_pkg::NUM_NODES-1:0]            up_valid;
	logic [art_cfg_pkg::NUM_NODES*DATA_WIDTH-1:0] up_data;

	////////////////////////////////////////////////////////////////////////////
	// configuration
	////////////////////////////////////////////////////////////////////////////

	art_config_regs u_cfg (
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_cfg_wr(i_cfg_wr),
		.i_cfg_node(i_cfg_node),
		.i_cfg_cmd(i_cfg_cmd),
		.o_node_cmd(node_cmd)
	);

	////////////////////////////////////////////////////////////////////////////
	// switch tree
	////////////////////////////////////////////////////////////////////////////

	for (genvar n = 0; n < art_cfg_pkg::NUM_NODES; n++)
	begin : g_node
		// children of this node, low = left
		logic [1:0]              child_valid;
		logic [2*DATA_WIDTH-1:0] child_data;

		if (art_cfg_pkg::node_level(n) == 1)
		begin : g_leaf_in
			// leaf pair 2n, 2n+1
			localparam int LANE = 2 * n;
			assign child_valid = i_leaf_valid[LANE +: 2];
			assign child_data = i_leaf_data[LANE*DATA_WIDTH +: 2*DATA_WIDTH];
		end
		else
		begin : g_node_in
			// node pair below, 4 -> 0/1, 5 -> 2/3, 6 -> 4/5
			localparam int CHILD = 2 * (n - art_cfg_pkg::LEVEL2_BASE);
			assign child_valid = up_valid[CHILD +: 2];
			assign child_data = up_data[CHILD*DATA_WIDTH +: 2*DATA_WIDTH];
		end

		adder_switch #(
			.DATA_WIDTH(DATA_WIDTH)
		) u_switch (
			.i_clk(i_clk),
			.i_reset(i_reset),
			.i_cmd(node_cmd[n]),
			.i_valid(child_valid),
			.i_data(child_data),
			.o_up_valid(up_valid[n]),
			.o_up_data(up_data[n*DATA_WIDTH +: DATA_WIDTH]),
			// emit output goes straight to slot n
			.o_out_valid(o_valid[n]),
			.o_out_data(o_data[n*DATA_WIDTH +: DATA_WIDTH])
		);
	end

endmodule

/* test/reduction_tree_asserts.sv */
`timescale 1ns/10ps

module reduction_tree_asserts (
	input logic                                                i_clk,
	input logic                                                i_reset,
	input logic [art_data_pkg::NUM_LEAVES-1:0]                 i_leaf_valid,
	input logic [art_cfg_pkg::NUM_NODES-1:0]                   i_slot_valid,
	input art_cfg_pkg::node_cmd_t [art_cfg_pkg::NUM_NODES-1:0] i_node_cmd
);

	// failures per property, summed by the testbench
	int unsigned reset_fails = 0;
	int unsigned emit_fails = 0;
	int unsigned idle_fails = 0;

	// emit field of every node as one vector
	logic [art_cfg_pkg::NUM_NODES-1:0] emit_bits;

	// consecutive cycles with no leaf valid, saturating
	logic [3:0] idle_run;

	always_comb
	begin
		for (int n = 0; n < art_cfg_pkg::NUM_NODES; n++)
			emit_bits[n] = i_node_cmd[n].emit;
	end

	always_ff @(posedge i_clk)
	begin
		if (i_reset || i_leaf_valid != '0)
			idle_run <= '0;
		else if (idle_run != 4'hf)
			idle_run <= idle_run + 4'd1;
	end

	reset_clears_slots: assert property (@(posedge i_clk) i_reset |=> (i_slot_valid == '0))
	else
	begin
		reset_fails++;
		$error("slot valid set in the cycle after reset");
	end

	// slot register loaded one edge earlier, under the command of that edge
	slot_needs_emit: assert property (@(posedge i_clk) disable iff (i_reset)
		(i_slot_valid & ~$past(emit_bits)) == '0)
	else
	begin
		emit_fails++;
		$error("slot valid on a node that was not emitting");
	end

	// deepest path drained after TREE_DEPTH idle cycles
	idle_tree_silent: assert property (@(posedge i_clk) disable iff (i_reset)
		(idle_run >= 4'(art_data_pkg::TREE_DEPTH)) |-> (i_slot_valid == '0))
	else
	begin
		idle_fails++;
		$error("slot valid although the leaves were idle long enough to drain");
	end

endmodule

bind reduction_tree reduction_tree_asserts u_asserts (
	.i_clk(i_clk),
	.i_reset(i_reset),
	.i_leaf_valid(i_leaf_valid),
	.i_slot_valid(o_valid),
	.i_node_cmd(node_cmd)
);

/* test/tb_reduction_tree.sv */
`timescale 1ns/10ps

module tb_reduction_tree;

	localparam int W = art_data_pkg::PSUM_WIDTH_DEF;
	localparam int NL = art_data_pkg::NUM_LEAVES;
	localparam int NN = art_cfg_pkg::NUM_NODES;
	localparam int DEPTH = art_data_pkg::TREE_DEPTH;

	// vectors per phase
	localparam int RESET_CYCLES = 16;
	localparam int N_IDLE = 20;
	localparam int N_PAIR = 40;
	localparam int N_FULL = 40;
	localparam int N_FWD = 30;
	localparam int N_MIX = 60;
	localparam int N_PHASES = 6;
	localparam int TOTAL_VECTORS = N_IDLE + N_PAIR + N_FULL + 2 * N_FWD + N_MIX;

	// config writes and gap cycles per phase plus the drain
	localparam int CYCLE_LIMIT = RESET_CYCLES + TOTAL_VECTORS + N_PHASES * (NN + 3)
		+ N_PHASES * DEPTH + 100;

	typedef logic [NN-1:0] slot_vec_t;
	typedef logic [W-1:0] word_t;
	typedef art_cfg_pkg::node_cmd_t [NN-1:0] cfg_vec_t;

	logic clk;
	logic reset;
	logic cfg_wr;
	art_cfg_pkg::node_idx_t cfg_node;
	art_cfg_pkg::node_cmd_t cfg_cmd;
	logic [NL-1:0] leaf_valid;
	logic [NL*W-1:0] leaf_data;
	slot_vec_t out_valid;
	logic [NN*W-1:0] out_data;

	// scoreboard with one queue per slot for due cycle and value
	int due_q [NN][$];
	word_t data_q [NN][$];

	int cycle = 0;
	cfg_vec_t cur_cfg;
	logic [31:0] rng;
	logic checking;
	int err_value;
	int err_missing;
	int n_checked;

	reduction_tree #(
		.DATA_WIDTH(W)
	) dut0 (
		.i_clk(clk),
		.i_reset(reset),
		.i_cfg_wr(cfg_wr),
		.i_cfg_node(cfg_node),
		.i_cfg_cmd(cfg_cmd),
		.i_leaf_valid(leaf_valid),
		.i_leaf_data(leaf_data),
		.o_valid(out_valid),
		.o_data(out_data)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#2 clk = ~clk;
	end

	// cycle count and watchdog
	always @(posedge clk)
	begin
		cycle <= cycle + 1;
		if (cycle >= CYCLE_LIMIT)
		begin
			$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Some tests failed");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic art_cfg_pkg::node_cmd_t build_cmd(input logic add, input logic sel,
		input logic emit);
		art_cfg_pkg::node_cmd_t c;
		c.add = add;
		c.sel = sel;
		c.emit = emit;
		return c;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////////////////////

	// expected slot outputs for one vector
	// latency added by the caller
	function automatic void ref_tree(input cfg_vec_t cfg, input logic [NL-1:0] lv,
		input logic [NL*W-1:0] ld, output slot_vec_t ev, output logic [NN*W-1:0] ed);
		logic [NN-1:0] up_v;
		word_t up_d [NN];
		logic [1:0] cv;
		word_t lo;
		word_t hi;
		logic rv;
		word_t rd;
		ev = '0;
		ed = '0;
		up_v = '0;
		up_d = '{default: '0};
		for (int n = 0; n < NN; n++)
		begin
			if (art_cfg_pkg::node_level(n) == 1)
			begin
				// leaf pair 2n, 2n+1
				cv = lv[2*n +: 2];
				lo = ld[2*n*W +: W];
				hi = ld[(2*n+1)*W +: W];
			end
			else
			begin
				// node 4 over 0/1, node 5 over 2/3, root over 4/5
				cv = up_v[2*(n-4) +: 2];
				lo = up_d[2*(n-4)];
				hi = up_d[2*(n-4)+1];
			end
			if (cfg[n].add)
			begin
				// both children or nothing
				rv = cv[0] & cv[1];
				rd = lo + hi;
			end
			else if (cfg[n].sel)
			begin
				rv = cv[1];
				rd = hi;
			end
			else
			begin
				rv = cv[0];
				rd = lo;
			end
			if (cfg[n].emit)
			begin
				ev[n] = rv;
				ed[n*W +: W] = rd;
			end
			else
			begin
				up_v[n] = rv;
				up_d[n] = rd;
			end
		end
	endfunction

	task automatic check_slots(input string name, input slot_vec_t got, input slot_vec_t exp);
		n_checked++;
		if (got !== exp)
		begin
			err_value++;
			$display("ERROR %s got %h expected %h at cycle %0d", name, got, exp, cycle);
		end
	endtask

	task automatic check_word(input string name, input word_t got, input word_t exp);
		n_checked++;
		if (got !== exp)
		begin
			err_value++;
			$display("ERROR %s got %h expected %h at cycle %0d", name, got, exp, cycle);
		end
	endtask

	// compare on the falling edge while outputs are settled
	always @(negedge clk)
	begin
		slot_vec_t exp_valid;
		if (checking)
		begin
			exp_valid = '0;
			for (int n = 0; n < NN; n++)
			begin
				if (due_q[n].size() > 0 && due_q[n][0] == cycle)
				begin
					exp_valid[n] = 1'b1;
					if (out_valid[n])
					begin
						check_word($sformatf("o_data[%0d]", n), out_data[n*W +: W],
							data_q[n][0]);
					end
					else
					begin
						err_missing++;
						$display("slot %0d result due at cycle %0d was never seen", n, cycle);
					end
					void'(due_q[n].pop_front());
					void'(data_q[n].pop_front());
				end
			end
			// valid exactly on the slots the model queued for this cycle
			check_slots("o_valid", out_valid, exp_valid);
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////////////////////

	task automatic load_config(input cfg_vec_t cfg);
		for (int n = 0; n < NN; n++)
		begin
			@(negedge clk);
			cfg_wr = 1'b1;
			cfg_node = art_cfg_pkg::node_idx_t'(n);
			cfg_cmd = cfg[n];
		end
		@(negedge clk);
		cfg_wr = 1'b0;
		cur_cfg = cfg;
	endtask

	// back-to-back vectors and a drain until the tree is empty
	task automatic send_vectors(input int count, input logic rand_valid);
		slot_vec_t ev;
		logic [NN*W-1:0] ed;
		logic [NL-1:0] vmask;
		for (int i = 0; i < count; i++)
		begin
			@(negedge clk);
			// two masks or-ed for about three lanes in four valid
			rng = xorshift32(rng);
			vmask = rng[NL-1:0];
			rng = xorshift32(rng);
			vmask = vmask | rng[NL-1:0];
			leaf_valid = rand_valid ? vmask : '1;
			for (int l = 0; l < NL; l++)
			begin
				rng = xorshift32(rng);
				leaf_data[l*W +: W] = word_t'(rng);
			end
			ref_tree(cur_cfg, leaf_valid, leaf_data, ev, ed);
			for (int n = 0; n < NN; n++)
			begin
				if (ev[n])
				begin
					due_q[n].push_back(cycle + art_cfg_pkg::node_level(n));
					data_q[n].push_back(ed[n*W +: W]);
				end
			end
		end
		@(negedge clk);
		leaf_valid = '0;
		repeat (DEPTH + 1)
			@(negedge clk);
	endtask

	initial
	begin
		cfg_vec_t cfg;
		int total;
		reset = 1'b1;
		cfg_wr = 1'b0;
		cfg_node = '0;
		cfg_cmd = '0;
		leaf_valid = '0;
		leaf_data = '0;
		cur_cfg = '0;
		rng = 32'h155a_8a9b;
		checking = 1'b0;
		err_value = 0;
		err_missing = 0;
		n_checked = 0;
		repeat (RESET_CYCLES)
			@(negedge clk);
		reset = 1'b0;
		checking = 1'b1;

		// idle after reset with nothing emitting
		repeat (N_IDLE)
			@(negedge clk);

		// four pair sums
		cfg = '0;
		for (int n = 0; n < 4; n++)
			cfg[n] = build_cmd(1'b1, 1'b0, 1'b1);
		load_config(cfg);
		send_vectors(N_PAIR, 1'b0);

		// full eight-way sum at the root
		for (int n = 0; n < NN - 1; n++)
			cfg[n] = build_cmd(1'b1, 1'b0, 1'b0);
		cfg[NN-1] = build_cmd(1'b1, 1'b0, 1'b1);
		load_config(cfg);
		send_vectors(N_FULL, 1'b0);

		// forwarding with node 4 emitting lane 3 and root emitting lane 4 + lane 7
		cfg[0] = build_cmd(1'b0, 1'b0, 1'b0);
		cfg[1] = build_cmd(1'b0, 1'b1, 1'b0);
		cfg[2] = build_cmd(1'b0, 1'b0, 1'b0);
		cfg[3] = build_cmd(1'b0, 1'b1, 1'b0);
		cfg[4] = build_cmd(1'b0, 1'b1, 1'b1);
		cfg[5] = build_cmd(1'b1, 1'b0, 1'b0);
		cfg[6] = build_cmd(1'b0, 1'b1, 1'b1);
		load_config(cfg);
		send_vectors(N_FWD, 1'b1);

		// other selects where root forwards node 4 as lane 1 + lane 2
		cfg[0] = build_cmd(1'b0, 1'b1, 1'b0);
		cfg[1] = build_cmd(1'b0, 1'b0, 1'b0);
		cfg[2] = build_cmd(1'b0, 1'b1, 1'b1);
		cfg[3] = build_cmd(1'b0, 1'b0, 1'b1);
		cfg[4] = build_cmd(1'b1, 1'b0, 1'b0);
		cfg[5] = build_cmd(1'b0, 1'b0, 1'b0);
		cfg[6] = build_cmd(1'b0, 1'b0, 1'b1);
		load_config(cfg);
		send_vectors(N_FWD, 1'b1);

		// mixed groups where node 4 and root never see two valid children
		cfg[0] = build_cmd(1'b1, 1'b0, 1'b1);
		for (int n = 1; n < 4; n++)
			cfg[n] = build_cmd(1'b1, 1'b0, 1'b0);
		for (int n = 4; n < NN; n++)
			cfg[n] = build_cmd(1'b1, 1'b0, 1'b1);
		load_config(cfg);
		send_vectors(N_MIX, 1'b1);

		// leftovers never reached their slot
		for (int n = 0; n < NN; n++)
		begin
			while (due_q[n].size() > 0)
			begin
				err_missing++;
				$display("slot %0d result due at cycle %0d never arrived", n, due_q[n][0]);
				void'(due_q[n].pop_front());
				void'(data_q[n].pop_front());
			end
		end

		total = err_value + err_missing + int'(dut0.u_asserts.reset_fails)
			+ int'(dut0.u_asserts.emit_fails) + int'(dut0.u_asserts.idle_fails);
		$display("checks %0d, value errors %0d, missing results %0d, assertion failures %0d",
			n_checked, err_value, err_missing, total - err_value - err_missing);
		if (total == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule
